// File: source/fas_num_pkg.sv
/*
  Number formats for the spectral peak detector.
  Internal parts carry 21 bits, enough for four butterfly layers on 16-bit input.
  Twiddles are Q16 and cover only the first half circle (k = 0..7 of 16).
*/
`default_nettype none

package fas_num_pkg;

  localparam int sample_width      = 16;
  localparam int acc_width         = 21;  // 16 + 4 stages + 1 margin
  localparam int twiddle_width     = 18;
  localparam int twiddle_frac_bits = 16;

  localparam int sample_max = 2 ** (sample_width - 1) - 1;
  localparam int sample_min = -(2 ** (sample_width - 1));

  typedef logic signed [sample_width-1:0] sample_t;

  typedef struct packed {
    logic signed [acc_width-1:0] re;
    logic signed [acc_width-1:0] im;
  } acc_cplx_t;

  typedef logic [2*sample_width-1:0] bin_t;   // {re, im}, 16 bits each
  typedef logic [2*sample_width:0]   mag_t;   // re^2 + im^2 never exceeds 2^31

  //////////////////////////////
  // Twiddles W16^k = cos - j*sin
  //////////////////////////////
  localparam logic signed [twiddle_width-1:0] w_real [0:7] = '{
    18'sd65536, 18'sd60547, 18'sd46340, 18'sd25079,
    18'sd0, -18'sd25079, -18'sd46340, -18'sd60547
  };

  localparam logic signed [twiddle_width-1:0] w_imag [0:7] = '{
    18'sd0, -18'sd25079, -18'sd46340, -18'sd60547,
    -18'sd65536, -18'sd60547, -18'sd46340, -18'sd25079
  };

endpackage

`default_nettype wire

// File: source/fas_frame_pkg.sv
/*
  Frame geometry. Frames are a fixed 16 points, radix 2, four layers.
*/
`default_nettype none

package fas_frame_pkg;

  localparam int frame_len  = 16;
  localparam int log2_frame = 4;

  typedef logic [log2_frame-1:0] bin_idx_t;

  // DIF output lands in bit-reversed order
  function automatic bin_idx_t bit_reverse(input bin_idx_t idx);
    bin_idx_t rev;
    for (int b = 0; b < log2_frame; b++) begin
      rev[b] = idx[log2_frame-1-b];
    end
    return rev;
  endfunction

endpackage

`default_nettype wire

// File: source/frame_collector.sv
/*
  Serial to parallel buffer. Counts valid samples modulo 16 from reset.
  There is no frame alignment input. frame updates only with frame_valid.
*/
`timescale 1ns/1ps
`default_nettype none

module frame_collector (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sample_valid,
  input  fas_num_pkg::sample_t sample,
  output logic                 frame_valid,
  output fas_num_pkg::sample_t frame [fas_frame_pkg::frame_len]
);

  import fas_num_pkg::*;
  import fas_frame_pkg::*;

  bin_idx_t wr_cnt;                       // Next slot to write
  logic     last_slot;
  sample_t  fill [frame_len-1];           // First 15 samples of the frame being built

  assign last_slot = (wr_cnt == bin_idx_t'(frame_len - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_cnt      <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= sample_valid && last_slot;
      if (sample_valid) begin
        wr_cnt <= wr_cnt + 1'b1;          // Wraps after slot 15
      end
    end
  end

  // Output frame is loaded in one step so it stays stable while the next fills
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      if (last_slot) begin
        for (int i = 0; i < frame_len - 1; i++) begin
          frame[i] <= fill[i];
        end
        frame[frame_len-1] <= sample;
      end else begin
        fill[wr_cnt] <= sample;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fft_stage.sv
/*
  One registered layer of radix-2 DIF butterflies.
  span must be 8, 4, 2 or 1. Twiddle products are floored (arithmetic shift).
  No overflow check; the caller sizes acc_width for the growth.
*/
`timescale 1ns/1ps
`default_nettype none

module fft_stage #(
  parameter int span = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  fas_num_pkg::acc_cplx_t in_data  [fas_frame_pkg::frame_len],
  output logic                   out_valid,
  output fas_num_pkg::acc_cplx_t out_data [fas_frame_pkg::frame_len]
);

  import fas_num_pkg::*;
  import fas_frame_pkg::*;

  acc_cplx_t next_data [frame_len];

  //////////////////////////////
  // Butterflies
  //////////////////////////////
  always_comb begin : butterflies
    acc_cplx_t a;
    acc_cplx_t b;
    logic signed [acc_width-1:0] d_re;
    logic signed [acc_width-1:0] d_im;
    logic signed [acc_width+twiddle_width:0] p_re;
    logic signed [acc_width+twiddle_width:0] p_im;
    int lo;
    int k;
    for (int g = 0; g < frame_len; g += 2 * span) begin
      for (int j = 0; j < span; j++) begin
        lo = g + j;
        k  = j * ((frame_len / 2) / span);  // Twiddle step grows as span shrinks
        a  = in_data[lo];
        b  = in_data[lo+span];

        next_data[lo].re = a.re + b.re;
        next_data[lo].im = a.im + b.im;

        d_re = a.re - b.re;
        d_im = a.im - b.im;
        p_re = d_re * w_real[k] - d_im * w_imag[k];
        p_im = d_re * w_imag[k] + d_im * w_real[k];

        // Drop the Q16 fraction, rounds toward minus infinity
        next_data[lo+span].re = p_re[twiddle_frac_bits +: acc_width];
        next_data[lo+span].im = p_im[twiddle_frac_bits +: acc_width];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= next_data;              // Holds between frames
    end
  end

endmodule

`default_nettype wire

// File: source/fft_pipeline.sv
/*
  16-point DIF FFT, four registered layers, latency 4 cycles.
  Accepts a new frame every cycle. Bins are clamped to 16 bits and
  reordered combinationally after the last layer.
*/
`timescale 1ns/1ps
`default_nettype none

module fft_pipeline (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_valid,
  input  fas_num_pkg::sample_t frame    [fas_frame_pkg::frame_len],
  output logic                 spectrum_valid,
  output fas_num_pkg::bin_t    spectrum [fas_frame_pkg::frame_len]
);

  import fas_num_pkg::*;
  import fas_frame_pkg::*;

  logic      stage_valid [log2_frame+1];
  acc_cplx_t stage_data  [log2_frame+1][frame_len];

  function automatic sample_t saturate(input logic signed [acc_width-1:0] v);
    if (v > sample_max) begin
      return sample_t'(sample_max);
    end else if (v < sample_min) begin
      return sample_t'(sample_min);
    end
    return sample_t'(v);
  endfunction

  assign stage_valid[0] = frame_valid;

  // Real input, imaginary part zero
  for (genvar i = 0; i < frame_len; i++) begin : extend_g
    assign stage_data[0][i].re = acc_width'(frame[i]);
    assign stage_data[0][i].im = '0;
  end

  for (genvar s = 0; s < log2_frame; s++) begin : stage_g
    fft_stage #(
      .span (frame_len >> (s + 1))      // 8, 4, 2, 1
    ) u_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (stage_valid[s]),
      .in_data   (stage_data[s]),
      .out_valid (stage_valid[s+1]),
      .out_data  (stage_data[s+1])
    );
  end

  assign spectrum_valid = stage_valid[log2_frame];

  always_comb begin
    for (int i = 0; i < frame_len; i++) begin
      spectrum[i] = {saturate(stage_data[log2_frame][bit_reverse(bin_idx_t'(i))].re),
                     saturate(stage_data[log2_frame][bit_reverse(bin_idx_t'(i))].im)};
    end
  end

endmodule

`default_nettype wire

// File: source/peak_finder.sv
/*
  Largest-magnitude bin search, latency 5 cycles, one frame per cycle.
  Ties go to the higher bin index.
*/
`timescale 1ns/1ps
`default_nettype none

module peak_finder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spectrum_valid,
  input  fas_num_pkg::bin_t      spectrum [fas_frame_pkg::frame_len],
  output logic                   peak_valid,
  output fas_frame_pkg::bin_idx_t peak_bin
);

  import fas_num_pkg::*;
  import fas_frame_pkg::*;

  // Binary tree kept as a heap: node n has children 2n and 2n+1,
  // leaves frame_len..2*frame_len-1 hold bins 0..15
  mag_t     node_mag [1:2*frame_len-1];
  bin_idx_t node_idx [1:2*frame_len-1];

  logic [log2_frame:0] vld;               // vld[0] leaves, vld[4] root

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[log2_frame-1:0], spectrum_valid};
    end
  end

  //////////////////////////////
  // Magnitude squared
  //////////////////////////////
  for (genvar i = 0; i < frame_len; i++) begin : leaf_g
    logic signed [sample_width-1:0]   re;
    logic signed [sample_width-1:0]   im;
    logic signed [2*sample_width-1:0] sq_re;
    logic signed [2*sample_width-1:0] sq_im;

    assign re    = spectrum[i][2*sample_width-1:sample_width];
    assign im    = spectrum[i][sample_width-1:0];
    assign sq_re = re * re;                // At most 2^30, never negative
    assign sq_im = im * im;

    always_ff @(posedge clk) begin
      if (spectrum_valid) begin
        node_mag[frame_len+i] <= {1'b0, sq_re} + {1'b0, sq_im};
        node_idx[frame_len+i] <= bin_idx_t'(i);
      end
    end
  end

  //////////////////////////////
  // Compare tree
  //////////////////////////////
  for (genvar n = 1; n < frame_len; n++) begin : node_g
    // Loads when its children's level is valid
    always_ff @(posedge clk) begin
      if (vld[log2_frame-$clog2(n+1)]) begin
        if (node_mag[2*n] > node_mag[2*n+1]) begin  // Left only if strictly larger
          node_mag[n] <= node_mag[2*n];
          node_idx[n] <= node_idx[2*n];
        end else begin
          node_mag[n] <= node_mag[2*n+1];
          node_idx[n] <= node_idx[2*n+1];
        end
      end
    end
  end

  assign peak_valid = vld[log2_frame];
  assign peak_bin   = node_idx[1];

endmodule

`default_nettype wire

// File: source/spectral_peak.sv
/*
  Spectral peak detector top. Serial samples in, 16-bin spectrum and peak
  index out. spectrum_valid 4 cycles and peak_valid 9 cycles after frame_valid.
  No back-pressure; samples are accepted on every sample_valid.
*/
`timescale 1ns/1ps
`default_nettype none

module spectral_peak (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sample_valid,
  input  fas_num_pkg::sample_t    sample,
  output logic                    spectrum_valid,
  output fas_num_pkg::bin_t       spectrum [fas_frame_pkg::frame_len],
  output logic                    peak_valid,
  output fas_frame_pkg::bin_idx_t peak_bin
);

  import fas_num_pkg::*;
  import fas_frame_pkg::*;

  logic    frame_valid;
  sample_t frame [frame_len];             // Collector to FFT

  frame_collector u_collector (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample       (sample),
    .frame_valid  (frame_valid),
    .frame        (frame)
  );

  fft_pipeline u_fft (
    .clk            (clk),
    .rst            (rst),
    .frame_valid    (frame_valid),
    .frame          (frame),
    .spectrum_valid (spectrum_valid),
    .spectrum       (spectrum)
  );

  peak_finder u_peak (
    .clk            (clk),
    .rst            (rst),
    .spectrum_valid (spectrum_valid),
    .spectrum       (spectrum),
    .peak_valid     (peak_valid),
    .peak_bin       (peak_bin)
  );

endmodule

`default_nettype wire

// File: tests/spectral_peak_vectors.svh
/*
  Test frames for the spectral peak testbench, included in the module body.
  Random amplitudes are limited to 1..1000 by the testbench.
*/
`ifndef SPECTRAL_PEAK_VECTORS_SVH
`define SPECTRAL_PEAK_VECTORS_SVH

// Frame patterns
localparam int kind_const   = 0;          // c on every slot
localparam int kind_alt     = 1;          // +a, -a, +a, ...
localparam int kind_impulse = 2;          // a on slot 0 only
localparam int kind_quarter = 3;          // a, 0, -a, 0 repeated

// Columns: kind, amplitude, random amplitude, random gaps, expected peak bin
typedef struct packed {
  int kind;
  int amp;
  bit rand_amp;
  bit gaps;
  int peak;
} vector_t;

localparam int n_vectors = 13;

localparam vector_t vectors [n_vectors] = '{
  '{kind_const,    100, 1'b0, 1'b0,  0},
  '{kind_alt,      200, 1'b0, 1'b0,  8},
  '{kind_impulse,  300, 1'b0, 1'b0, 15},  // All bins equal, highest index wins
  '{kind_quarter,   50, 1'b0, 1'b0, 12},  // Tie between bins 4 and 12
  '{kind_const,   4000, 1'b0, 1'b0,  0},  // Bin 0 clamps high
  '{kind_const,  -4000, 1'b0, 1'b1,  0},  // Bin 0 clamps low
  '{kind_alt,        0, 1'b1, 1'b1,  8},
  '{kind_impulse,    0, 1'b1, 1'b1, 15},
  '{kind_quarter,    0, 1'b1, 1'b1, 12},
  '{kind_const,      0, 1'b1, 1'b0,  0},
  '{kind_alt,     2047, 1'b0, 1'b0,  8},  // Largest value that still fits
  '{kind_alt,     3000, 1'b0, 1'b0,  8},
  '{kind_quarter,    0, 1'b1, 1'b1, 12}
};

`endif

// File: tests/spectral_peak_tb.sv
/*
  Testbench for spectral_peak. Expected bins follow closed-form rules for
  four real input patterns, so only those patterns are checked.
  Outputs are sampled on the falling clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module spectral_peak_tb;

  `include "spectral_peak_vectors.svh"

  localparam int drain_limit = 40;        // Cycles allowed for the last results

  logic        clk = 1'b0;
  logic        rst;
  logic        sample_valid;
  logic [15:0] sample;
  logic        spectrum_valid;
  logic [31:0] spectrum [16];
  logic        peak_valid;
  logic [3:0]  peak_bin;

  int          cycle = 0;                 // Rising edges since start
  logic [31:0] rng;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_errs [n_vectors];

  // Frames waiting for spectrum, then for peak
  int spec_idx_q [$];
  int spec_amp_q [$];
  int spec_due_q [$];
  int peak_idx_q [$];
  int peak_amp_q [$];
  int peak_due_q [$];

  spectral_peak dut (
    .clk            (clk),
    .rst            (rst),
    .sample_valid   (sample_valid),
    .sample         (sample),
    .spectrum_valid (spectrum_valid),
    .spectrum       (spectrum),
    .peak_valid     (peak_valid),
    .peak_bin       (peak_bin)
  );

  always #50 clk = ~clk;                  // 100 ns period

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////
  // Stimulus and reference model
  //////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int pattern_sample(input int kind, input int amp, input int slot);
    case (kind)
      kind_const:   return amp;
      kind_alt:     return (slot % 2 == 0) ? amp : -amp;
      kind_impulse: return (slot == 0) ? amp : 0;
      default:      return (slot % 4 == 0) ? amp : ((slot % 4 == 2) ? -amp : 0);
    endcase
  endfunction

  function automatic logic [15:0] clamp16(input int v);
    if (v > 32767) return 16'h7fff;
    if (v < -32768) return 16'h8000;
    return v[15:0];
  endfunction

  // Real input patterns give purely real bins
  function automatic logic [31:0] expected_bin(input int kind, input int amp, input int bin);
    int re;
    re = 0;
    case (kind)
      kind_const:   if (bin == 0) re = 16 * amp;
      kind_alt:     if (bin == 8) re = 16 * amp;
      kind_impulse: re = amp;
      default:      if (bin == 4 || bin == 12) re = 8 * amp;
    endcase
    return {clamp16(re), 16'h0000};
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      kind_const:   return "constant";
      kind_alt:     return "alternating";
      kind_impulse: return "impulse";
      default:      return "quarter";
    endcase
  endfunction

  task automatic check_value(input int test, input logic [31:0] got,
                             input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("CHECK FAILED at time %0t: test %0d %s got %0h expected %0h",
               $time, test, what, got, exp);
      errors++;
      test_errs[test]++;
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////
  always @(negedge clk) begin : monitor
    int idx;
    int amp;
    int due;
    if (spectrum_valid) begin
      assert (spec_idx_q.size() > 0) else begin
        $display("Unexpected spectrum_valid at time %0t with no frame outstanding", $time);
        errors++;
      end
      if (spec_idx_q.size() > 0) begin
        idx = spec_idx_q.pop_front();
        amp = spec_amp_q.pop_front();
        due = spec_due_q.pop_front();
        check_value(idx, cycle, due, "spectrum_valid cycle");
        for (int b = 0; b < 16; b++) begin
          check_value(idx, spectrum[b], expected_bin(vectors[idx].kind, amp, b),
                      $sformatf("bin %0d", b));
        end
        peak_idx_q.push_back(idx);
        peak_amp_q.push_back(amp);
        peak_due_q.push_back(cycle + 5);  // Peak search latency
      end
    end
    if (peak_valid) begin
      assert (peak_idx_q.size() > 0) else begin
        $display("Unexpected peak_valid at time %0t with no spectrum outstanding", $time);
        errors++;
      end
      if (peak_idx_q.size() > 0) begin
        idx = peak_idx_q.pop_front();
        amp = peak_amp_q.pop_front();
        due = peak_due_q.pop_front();
        check_value(idx, cycle, due, "peak_valid cycle");
        check_value(idx, peak_bin, vectors[idx].peak, "peak_bin");
        if (test_errs[idx] == 0) tests_passed++;
        else tests_failed++;
        $display("test %0d %s amp %0d: %s", idx, kind_name(vectors[idx].kind), amp,
                 (test_errs[idx] == 0) ? "ok" : "FAILED");
      end
    end
  end

  //////////////////////////////
  // Driver
  //////////////////////////////
  initial begin : stimulus
    int amp;
    int gap;
    int waited;
    rst          = 1'b1;
    sample_valid = 1'b0;
    sample       = '0;
    rng          = 32'h0067_6fee;
    foreach (test_errs[i]) test_errs[i] = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) begin                      // Idle, no strobe may appear
      @(posedge clk);
      #1;
    end
    for (int v = 0; v < n_vectors; v++) begin
      amp = vectors[v].amp;
      if (vectors[v].rand_amp) begin
        rng = xorshift32(rng);
        amp = int'(rng % 1000) + 1;
      end
      for (int slot = 0; slot < 16; slot++) begin
        if (vectors[v].gaps) begin
          rng = xorshift32(rng);
          gap = int'(rng % 4);
          repeat (gap) begin
            sample_valid = 1'b0;
            sample       = rng[15:0];     // Junk without strobe
            @(posedge clk);
            #1;
          end
        end
        sample_valid = 1'b1;
        sample       = 16'(pattern_sample(vectors[v].kind, amp, slot));
        if (slot == 15) begin
          spec_idx_q.push_back(v);
          spec_amp_q.push_back(amp);
          spec_due_q.push_back(cycle + 5); // Taken at next edge, then 4 layers
        end
        @(posedge clk);
        #1;
      end
    end
    sample_valid = 1'b0;
    for (waited = 0; waited < drain_limit &&
         (spec_idx_q.size() + peak_idx_q.size()) > 0; waited++) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);            // Catch stray strobes
    if ((spec_idx_q.size() + peak_idx_q.size()) > 0) begin
      $display("Timeout: %0d frames still waiting for results",
               spec_idx_q.size() + peak_idx_q.size());
      $display("Done: errors found");
      $finish;
    end else begin
      $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
      if (errors == 0 && tests_passed == n_vectors) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: spectral_peak.f
+incdir+tests
source/fas_num_pkg.sv
source/fas_frame_pkg.sv
source/frame_collector.sv
source/fft_stage.sv
source/fft_pipeline.sv
source/peak_finder.sv
source/spectral_peak.sv
tests/spectral_peak_tb.sv

// File: Bender.yml
package:
  name: spectral_peak

sources:
  - files:
      - source/fas_num_pkg.sv
      - source/fas_frame_pkg.sv
      - source/frame_collector.sv
      - source/fft_stage.sv
      - source/fft_pipeline.sv
      - source/peak_finder.sv
      - source/spectral_peak.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/spectral_peak_tb.sv
